// File: Makefile
# Verilator flow for the music box

TOP = musicBoxTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f files.f

# Exit status comes from the pass line search
sim:
	verilator --binary --timing --top-module $(TOP) -f files.f -o $(TOP)
	./obj_dir/$(TOP) | awk '{ print } /^test passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// File: files.f
rtl/musicBoxPkg.sv
rtl/tickTimer.sv
rtl/buttonDebouncer.sv
rtl/playModeFsm.sv
rtl/toneSynth.sv
rtl/dacSerializer.sv
rtl/musicBoxTop.sv
sim/musicBoxTb.sv

// File: rtl/buttonDebouncer.sv
//--------------------
// Button debouncer
// Syncs the six keys and the bee button, filters them on the debounce
// tick and pulses beePress on each clean press of the bee button
//--------------------
`timescale 1ns/100ps
`default_nettype none

module buttonDebouncer #(
	parameter int StableCount = 3 // Equal samples in a row before a flip
) (
	input  logic                 clock50Mhz,
	input  logic                 arstN,
	input  logic                 debounceTick,
	input  logic [musicBoxPkg::KeyCount-1:0] musicKeysN, // Active low pins
	input  logic                 beeButtonN,  // Active low pin
	output musicBoxPkg::keyMaskT keys,        // Clean, active high
	output logic                 beePress     // One cycle per press
);

	localparam int InputCount = musicBoxPkg::KeyCount + 1; // Bee button on top
	localparam int CntWidth   = $clog2(StableCount + 1);

	logic [InputCount-1:0] syncMeta;  // First sync stage
	logic [InputCount-1:0] syncPins;  // Second stage, active high
	logic [InputCount-1:0] stable;    // Debounced state
	logic [CntWidth-1:0]   diffCnt [InputCount]; // Ticks in a row that differ
	logic                  beeDly;    // Last debounced bee level

	// Two flop sync, invert to active high
	always_ff @(posedge clock50Mhz or negedge arstN) begin
		if (!arstN) begin
			syncMeta <= '0;
			syncPins <= '0;
		end else begin
			syncMeta <= ~{beeButtonN, musicKeysN};
			syncPins <= syncMeta;
		end
	end

	//--------------------
	// Stable sample filter
	always_ff @(posedge clock50Mhz or negedge arstN) begin
		if (!arstN) begin
			stable <= '0;
			for (int i = 0; i < InputCount; i++) begin
				diffCnt[i] <= '0;
			end
		end else if (debounceTick) begin
			for (int i = 0; i < InputCount; i++) begin
				if (syncPins[i] == stable[i]) begin
					diffCnt[i] <= '0; // Bounce back, start over
				end else if (diffCnt[i] == CntWidth'(StableCount - 1)) begin
					stable[i]  <= syncPins[i]; // Held long enough
					diffCnt[i] <= '0;
				end else begin
					diffCnt[i] <= diffCnt[i] + 1'b1;
				end
			end
		end
	end

	// Edge detect on the clean bee level
	always_ff @(posedge clock50Mhz or negedge arstN) begin
		if (!arstN) begin
			beeDly <= 1'b0;
		end else begin
			beeDly <= stable[InputCount-1];
		end
	end

	assign keys     = stable[InputCount-2:0];
	assign beePress = stable[InputCount-1] & ~beeDly; // Rising edge only

endmodule

`default_nettype wire

// File: rtl/dacSerializer.sv
//--------------------
// DAC serializer
// Acknowledge side of the sample handshake, sends each sample as a
// 16 bit SPI frame MSB first, two clocks per bit
//--------------------
`timescale 1ns/100ps
`default_nettype none

module dacSerializer (
	input  logic                clock50Mhz,
	input  logic                arstN,
	input  logic                sampleReq,
	input  musicBoxPkg::sampleT sample,
	output logic                sampleAck,
	output logic                dacSclk,  // Also the SCLK phase flop
	output logic                dacSyncN, // Low for the whole frame
	output logic                dacDin
);

	localparam int BitCntWidth = $clog2(musicBoxPkg::FrameWidth);

	logic [musicBoxPkg::FrameWidth-1:0] frame; // Shift register, MSB goes out
	logic [BitCntWidth-1:0] bitCnt;    // Bit now on dacDin
	logic                   startPend; // Frame latched, sync not yet low
	logic                   idle;
	logic                   latch;     // Take a new sample this cycle
	logic                   lastBit;
	logic                   shiftBit;  // Falling edge moving to the next bit

	assign idle     = dacSyncN && !startPend && !sampleAck;
	assign latch    = idle && sampleReq;
	assign lastBit  = (bitCnt == BitCntWidth'(musicBoxPkg::FrameWidth - 1));
	assign shiftBit = !dacSyncN && dacSclk && !lastBit;

	// Frame register
	always_ff @(posedge clock50Mhz) begin
		if (latch) begin
			frame <= {{musicBoxPkg::DacCtrlWidth{1'b0}}, sample}; // Normal mode bits
		end else if (shiftBit) begin
			frame <= {frame[musicBoxPkg::FrameWidth-2:0], 1'b0};
		end
	end

	//--------------------
	// Acknowledge side
	always_ff @(posedge clock50Mhz or negedge arstN) begin
		if (!arstN) begin
			sampleAck <= 1'b0;
		end else if (latch) begin
			sampleAck <= 1'b1;  // One cycle after req seen
		end else if (sampleAck && !sampleReq) begin
			sampleAck <= 1'b0;  // Req gone, close the handshake
		end
	end

	//--------------------
	// SPI timing
	always_ff @(posedge clock50Mhz or negedge arstN) begin
		if (!arstN) begin
			startPend <= 1'b0;
			dacSyncN  <= 1'b1;
			dacSclk   <= 1'b0;
			dacDin    <= 1'b0;
			bitCnt    <= '0;
		end else if (!dacSyncN) begin
			if (!dacSclk) begin
				dacSclk <= 1'b1; // Rise mid bit
			end else begin
				dacSclk <= 1'b0; // DAC takes the bit here
				if (lastBit) begin
					dacSyncN <= 1'b1; // 16th fall ends the frame
					dacDin   <= 1'b0;
				end else begin
					dacDin <= frame[musicBoxPkg::FrameWidth-2];
					bitCnt <= bitCnt + 1'b1;
				end
			end
		end else if (startPend) begin
			startPend <= 1'b0;
			dacSyncN  <= 1'b0;  // Cycle after the latch
			dacSclk   <= 1'b0;
			dacDin    <= frame[musicBoxPkg::FrameWidth-1];
			bitCnt    <= '0;
		end else if (latch) begin
			startPend <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/musicBoxPkg.sv
//--------------------
// Music box shared definitions
// Widths, key and sample types, play state enum and the tone table
//--------------------
`default_nettype none

package musicBoxPkg;

	//--------------------
	// Widths
	localparam int KeyCount     = 6;  // Music keys on the box
	localparam int SampleWidth  = 12; // DAC resolution
	localparam int DacCtrlWidth = 4;  // Leading control bits, zero for normal mode
	localparam int FrameWidth   = DacCtrlWidth + SampleWidth; // 16 bit SPI frame

	localparam int HalfCountWidth = 4; // Holds the longest half period

	//--------------------
	// Types
	typedef logic [KeyCount-1:0]         keyMaskT; // One bit per key, high = held
	typedef logic [$clog2(KeyCount)-1:0] keyIdxT;  // Key number 0..5
	typedef logic [SampleWidth-1:0]      sampleT;  // One DAC sample

	// Play mode states
	typedef enum logic [1:0] {
		stIdle    = 2'd0, // Nothing sounding
		stKeyPlay = 2'd1, // A key is held
		stDrone   = 2'd2  // Bee mode keeps the last key going
	} playStateT;

	//--------------------
	// Tone table
	localparam sampleT ToneAmplitude = 12'h600; // High half of the square wave

	// Half period in sample ticks, index 0 is the lowest key
	// Key 0 sits in the rightmost slot
	localparam logic [KeyCount-1:0][HalfCountWidth-1:0] ToneHalfPeriod = {
		4'd3, // Key 5
		4'd4, // Key 4
		4'd5, // Key 3
		4'd6, // Key 2
		4'd7, // Key 1
		4'd8  // Key 0
	};

endpackage

`default_nettype wire

// File: rtl/musicBoxTop.sv
//--------------------
// Music box top
// Keys in, square wave tone out to the speaker DAC over SPI
//--------------------
`timescale 1ns/100ps
`default_nettype none

module musicBoxTop #(
	parameter int SampleDiv   = 2268,  // About 22 kHz, keep at 40 or more
	parameter int DebounceDiv = 50000, // 1 ms
	parameter int StableCount = 3
) (
	input  logic       clock50Mhz,
	input  logic       arstN,
	input  logic [5:0] musicKeysN, // Active low keys
	input  logic       beeButtonN, // Active low
	output logic       dacSclk,
	output logic       dacSyncN,
	output logic       dacDin,
	output logic       beeLed
);

	logic                 sampleTick;
	logic                 debounceTick;
	musicBoxPkg::keyMaskT keys;
	logic                 beePress;
	logic                 toneOn;
	musicBoxPkg::keyIdxT  toneKey;
	logic                 sampleReq;
	logic                 sampleAck;
	musicBoxPkg::sampleT  sample;

	//--------------------
	// Enables and inputs
	tickTimer #(.SampleDiv(SampleDiv), .DebounceDiv(DebounceDiv)) uTickTimer (
		.clock50Mhz(clock50Mhz), .arstN(arstN),
		.sampleTick(sampleTick), .debounceTick(debounceTick)
	);

	buttonDebouncer #(.StableCount(StableCount)) uButtonDebouncer (
		.clock50Mhz(clock50Mhz), .arstN(arstN), .debounceTick(debounceTick),
		.musicKeysN(musicKeysN), .beeButtonN(beeButtonN),
		.keys(keys), .beePress(beePress)
	);

	// Which key sounds
	playModeFsm uPlayModeFsm (
		.clock50Mhz(clock50Mhz), .arstN(arstN), .keys(keys), .beePress(beePress),
		.toneOn(toneOn), .toneKey(toneKey), .beeLed(beeLed)
	);

	//--------------------
	// Audio path
	toneSynth uToneSynth (
		.clock50Mhz(clock50Mhz), .arstN(arstN), .sampleTick(sampleTick),
		.toneOn(toneOn), .toneKey(toneKey), .sampleAck(sampleAck),
		.sampleReq(sampleReq), .sample(sample)
	);

	dacSerializer uDacSerializer (
		.clock50Mhz(clock50Mhz), .arstN(arstN), .sampleReq(sampleReq),
		.sample(sample), .sampleAck(sampleAck),
		.dacSclk(dacSclk), .dacSyncN(dacSyncN), .dacDin(dacDin)
	);

endmodule

`default_nettype wire

// File: rtl/playModeFsm.sv
//--------------------
// Play mode FSM
// Picks the sounding key, keeps the bee toggle and the drone hold
//--------------------
`timescale 1ns/100ps
`default_nettype none

module playModeFsm (
	input  logic                 clock50Mhz,
	input  logic                 arstN,
	input  musicBoxPkg::keyMaskT keys,     // Debounced keys
	input  logic                 beePress, // Toggles bee mode
	output logic                 toneOn,
	output musicBoxPkg::keyIdxT  toneKey,
	output logic                 beeLed    // Bee mode indicator
);

	musicBoxPkg::playStateT state;
	musicBoxPkg::playStateT stateNext;

	logic beeMode;     // Toggle flag
	logic beeModeNext; // Flag as it will be next cycle
	logic anyKey;

	// Lowest held key wins
	function automatic musicBoxPkg::keyIdxT lowestKey(input musicBoxPkg::keyMaskT mask);
		musicBoxPkg::keyIdxT idx;
		idx = '0;
		for (int i = musicBoxPkg::KeyCount - 1; i >= 0; i--) begin
			if (mask[i]) begin
				idx = musicBoxPkg::keyIdxT'(i);
			end
		end
		return idx;
	endfunction

	assign anyKey      = |keys;
	assign beeModeNext = beeMode ^ beePress; // Press seen in the same cycle

	//--------------------
	// Next state
	always_comb begin
		stateNext = state;
		case (state)
			musicBoxPkg::stIdle: begin
				if (anyKey) stateNext = musicBoxPkg::stKeyPlay;
			end
			musicBoxPkg::stKeyPlay: begin
				if (!anyKey) begin
					stateNext = beeModeNext ? musicBoxPkg::stDrone : musicBoxPkg::stIdle;
				end
			end
			musicBoxPkg::stDrone: begin
				if (anyKey) begin
					stateNext = musicBoxPkg::stKeyPlay;     // New key takes over
				end else if (!beeModeNext) begin
					stateNext = musicBoxPkg::stIdle;        // Bee off stops the drone
				end
			end
			default: stateNext = musicBoxPkg::stIdle;
		endcase
	end

	// State, bee flag and key register
	always_ff @(posedge clock50Mhz or negedge arstN) begin
		if (!arstN) begin
			state   <= musicBoxPkg::stIdle;
			beeMode <= 1'b0;
			toneKey <= '0;
		end else begin
			state   <= stateNext;
			beeMode <= beeModeNext;
			if (anyKey) toneKey <= lowestKey(keys); // Drone keeps the old key
		end
	end

	assign toneOn = (state != musicBoxPkg::stIdle);
	assign beeLed = beeMode;

endmodule

`default_nettype wire

// File: rtl/tickTimer.sv
//--------------------
// Tick timer
// Free running dividers that give the sample and debounce enables
//--------------------
`timescale 1ns/100ps
`default_nettype none

module tickTimer #(
	parameter int SampleDiv   = 2268,  // Clocks per sample tick
	parameter int DebounceDiv = 50000  // Clocks per debounce tick
) (
	input  logic clock50Mhz,
	input  logic arstN,
	output logic sampleTick,  // One cycle every SampleDiv clocks
	output logic debounceTick // One cycle every DebounceDiv clocks
);

	localparam int SampleCntWidth   = $clog2(SampleDiv);
	localparam int DebounceCntWidth = $clog2(DebounceDiv);

	logic [SampleCntWidth-1:0]   sampleCnt;   // Counts down to zero
	logic [DebounceCntWidth-1:0] debounceCnt;

	// Sample divider, first tick lands SampleDiv clocks after reset
	always_ff @(posedge clock50Mhz or negedge arstN) begin
		if (!arstN) begin
			sampleCnt <= SampleCntWidth'(SampleDiv - 1);
		end else if (sampleCnt == '0) begin
			sampleCnt <= SampleCntWidth'(SampleDiv - 1); // Reload
		end else begin
			sampleCnt <= sampleCnt - 1'b1;
		end
	end

	// Debounce divider
	always_ff @(posedge clock50Mhz or negedge arstN) begin
		if (!arstN) begin
			debounceCnt <= DebounceCntWidth'(DebounceDiv - 1);
		end else if (debounceCnt == '0) begin
			debounceCnt <= DebounceCntWidth'(DebounceDiv - 1);
		end else begin
			debounceCnt <= debounceCnt - 1'b1;
		end
	end

	assign sampleTick   = (sampleCnt == '0);   // Enable, not a clock
	assign debounceTick = (debounceCnt == '0);

endmodule

`default_nettype wire

// File: rtl/toneSynth.sv
//--------------------
// Tone synthesizer
// Square wave from the tone table, one sample per accepted tick,
// request side of the sample handshake
//--------------------
`timescale 1ns/100ps
`default_nettype none

module toneSynth (
	input  logic                clock50Mhz,
	input  logic                arstN,
	input  logic                sampleTick,
	input  logic                toneOn,
	input  musicBoxPkg::keyIdxT toneKey,
	input  logic                sampleAck,
	output logic                sampleReq,
	output musicBoxPkg::sampleT sample
);

	logic [musicBoxPkg::HalfCountWidth-1:0] halfCnt;  // Ticks into this half
	logic [musicBoxPkg::HalfCountWidth-1:0] halfLen;  // Half period of toneKey
	logic                phaseHigh;  // Wave phase
	logic                toneOnDly;
	musicBoxPkg::keyIdxT lastKey;
	logic                restart;    // Key change or tone start
	logic                tickAccept; // Tick with the handshake idle

	assign halfLen    = musicBoxPkg::ToneHalfPeriod[toneKey];
	assign restart    = (toneKey != lastKey) || (toneOn && !toneOnDly);
	assign tickAccept = sampleTick && !sampleReq && !sampleAck; // Else dropped

	//--------------------
	// Wave phase
	always_ff @(posedge clock50Mhz or negedge arstN) begin
		if (!arstN) begin
			phaseHigh <= 1'b1;
			halfCnt   <= '0;
			toneOnDly <= 1'b0;
			lastKey   <= '0;
		end else begin
			toneOnDly <= toneOn;
			lastKey   <= toneKey;
			if (restart) begin
				phaseHigh <= 1'b1; // Every new note starts high
				halfCnt   <= '0;
			end else if (tickAccept && toneOn) begin
				if (halfCnt == halfLen - 1'b1) begin
					phaseHigh <= ~phaseHigh; // End of half period
					halfCnt   <= '0;
				end else begin
					halfCnt <= halfCnt + 1'b1;
				end
			end
		end
	end

	// Sample value, stable while the request is up
	always_ff @(posedge clock50Mhz) begin
		if (tickAccept) begin
			sample <= (toneOn && (phaseHigh || restart)) ? musicBoxPkg::ToneAmplitude : '0;
		end
	end

	//--------------------
	// Request side, four phase
	always_ff @(posedge clock50Mhz or negedge arstN) begin
		if (!arstN) begin
			sampleReq <= 1'b0;
		end else if (tickAccept) begin
			sampleReq <= 1'b1;  // Rises one cycle after the tick
		end else if (sampleReq && sampleAck) begin
			sampleReq <= 1'b0;  // Taken, drop it
		end
	end

endmodule

`default_nettype wire

// File: sim/musicBoxTb.sv
//--------------------
// Music box testbench
// Drives keys and the bee button from a table, decodes the DAC SPI
// frames and checks silence, tone half periods, priority and bee drone
//--------------------
`timescale 1ns/100ps
`default_nettype none

module musicBoxTb;

	localparam int SampleDiv   = 48;
	localparam int DebounceDiv = 16;
	localparam int StableCount = 3;
	localparam int SkipFrames  = 6;               // Debouncer and FSM settle
	localparam int BeeHold     = 8 * DebounceDiv; // Clocks the bee button stays down
	localparam logic [15:0] ToneValue = 16'h0600; // High half of the wave
	localparam int HalfPeriod [6] = '{8, 7, 6, 5, 4, 3}; // Frames per half, key 0 first

	typedef struct {
		string      name;
		logic [5:0] keyMask;   // Held keys, high = pressed
		bit         beeToggle; // Press the bee button once
		bit         silent;    // Expect all zero frames
		int         expKey;
		bit         expBee;
	} rowT;

	logic       clock50Mhz;
	logic       arstN;
	logic [5:0] musicKeysN;
	logic       beeButtonN;
	logic       dacSclk;
	logic       dacSyncN;
	logic       dacDin;
	logic       beeLed;

	rowT         rows [$];
	logic [15:0] frameVals [$];  // Decoded frames, oldest first
	int          frameFalls [$]; // SCLK falls per frame
	logic        frameBee [$];   // beeLed at frame end
	int          errCount   = 0;
	int          cycleCnt   = 0;
	int          cycleLimit = 0; // Armed once the table is built

	musicBoxTop #(
		.SampleDiv(SampleDiv), .DebounceDiv(DebounceDiv), .StableCount(StableCount)
	) dut (
		.clock50Mhz(clock50Mhz), .arstN(arstN), .musicKeysN(musicKeysN),
		.beeButtonN(beeButtonN), .dacSclk(dacSclk), .dacSyncN(dacSyncN),
		.dacDin(dacDin), .beeLed(beeLed)
	);

	initial begin
		clock50Mhz = 1'b0;
		forever #4 clock50Mhz = ~clock50Mhz; // 8 ns period
	end

	//--------------------
	// SPI frame decoder
	logic [15:0] shiftReg  = '0;
	int          falls     = 0;
	logic        prevSyncN = 1'b1;

	always @(posedge clock50Mhz) begin
		if (!arstN) begin
			prevSyncN = 1'b1; // Pins are not valid before reset takes hold
		end else begin
			if (!dacSyncN && prevSyncN) begin
				shiftReg = '0; // Frame start
				falls    = 0;
			end
			if (!dacSyncN && dacSclk) begin
				shiftReg = {shiftReg[14:0], dacDin}; // SCLK falls on this edge
				falls++;
			end
			if (dacSyncN && !prevSyncN) begin
				frameVals.push_back(shiftReg); // Sync back high, frame done
				frameFalls.push_back(falls);
				frameBee.push_back(beeLed);
			end
			prevSyncN = dacSyncN;
		end
	end

	// Cycle limit
	always @(posedge clock50Mhz) begin
		cycleCnt++;
		if (cycleLimit != 0 && cycleCnt >= cycleLimit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("test failed");
			$finish;
		end
	end

	//--------------------
	function automatic void addRow(input string name, input logic [5:0] keyMask,
			input bit beeToggle, input bit silent, input int expKey, input bit expBee);
		rowT r;
		r.name      = name;
		r.keyMask   = keyMask;
		r.beeToggle = beeToggle;
		r.silent    = silent;
		r.expKey    = expKey;
		r.expBee    = expBee;
		rows.push_back(r);
	endfunction

	task automatic releaseReset;
		arstN <= 1'b1;
	endtask

	task automatic driveKeys(input logic [5:0] keyMask);
		@(posedge clock50Mhz);
		musicKeysN <= ~keyMask; // Pins are active low
	endtask

	task automatic pressBee;
		@(posedge clock50Mhz);
		beeButtonN <= 1'b0;
		repeat (BeeHold) @(posedge clock50Mhz);
		beeButtonN <= 1'b1;
	endtask

	// Next frame off the decoder, format checked here
	task automatic takeFrame(input string name, output logic [15:0] value, output logic bee);
		int n;
		while (frameVals.size() == 0) begin
			@(posedge clock50Mhz);
		end
		value = frameVals.pop_front();
		n     = frameFalls.pop_front();
		bee   = frameBee.pop_front();
		if (n != 16) begin
			$display("ERR %s: SCLK falls expected 16 actual %0d", name, n);
			errCount++;
		end
		if (value[15:12] != 4'h0) begin
			$display("ERR %s: control bits expected 0 actual %h", name, value[15:12]);
			errCount++;
		end
	endtask

	// Square wave levels and full run lengths between changes
	task automatic checkTone(input string name, input logic [15:0] vals [$], input int expHalf);
		int runLen   = 1;
		int fullRuns = 0;
		bit seenChange = 1'b0; // First run is partial
		foreach (vals[i]) begin
			if (vals[i] != 16'h0000 && vals[i] != ToneValue) begin
				$display("ERR %s: sample expected 000 or 600 actual %h", name, vals[i]);
				errCount++;
			end
		end
		for (int i = 1; i < vals.size(); i++) begin
			if (vals[i] == vals[i-1]) begin
				runLen++;
			end else begin
				if (seenChange) begin
					fullRuns++;
					if (runLen != expHalf) begin
						$display("ERR %s: run length expected %0d actual %0d",
							name, expHalf, runLen);
						errCount++;
					end
				end
				seenChange = 1'b1;
				runLen     = 1;
			end
		end
		if (fullRuns == 0) begin
			$display("%s: no complete half period seen in the checked frames", name);
			errCount++;
		end
	endtask

	//--------------------
	// Main sequence
	initial begin
		rowT         row;
		logic [15:0] value;
		logic        bee;
		logic [15:0] vals [$];
		int          hold;
		int          startErrs;
		int          failedRows = 0;
		arstN      = 1'b0;
		musicKeysN = '1;   // No key held
		beeButtonN = 1'b1;
		void'($urandom(64634));

		// name, keys, bee press, silent, key, beeLed
		addRow("silence", 6'b000000, 1'b0, 1'b1, 0, 1'b0);
		addRow("key0",    6'b000001, 1'b0, 1'b0, 0, 1'b0);
		addRow("key1",    6'b000010, 1'b0, 1'b0, 1, 1'b0);
		addRow("key2",    6'b000100, 1'b0, 1'b0, 2, 1'b0);
		addRow("key3",    6'b001000, 1'b0, 1'b0, 3, 1'b0);
		addRow("key4",    6'b010000, 1'b0, 1'b0, 4, 1'b0);
		addRow("key5",    6'b100000, 1'b0, 1'b0, 5, 1'b0);
		addRow("prio2",   6'b101100, 1'b0, 1'b0, 2, 1'b0); // Lowest held wins
		addRow("prio1",   6'b110010, 1'b0, 1'b0, 1, 1'b0);
		addRow("release", 6'b000000, 1'b0, 1'b1, 0, 1'b0);
		addRow("beeOn",   6'b000000, 1'b1, 1'b1, 0, 1'b1);
		addRow("beeKey4", 6'b010000, 1'b0, 1'b0, 4, 1'b1);
		addRow("drone4",  6'b000000, 1'b0, 1'b0, 4, 1'b1); // Keeps sounding
		addRow("beeKey1", 6'b000010, 1'b0, 1'b0, 1, 1'b1);
		addRow("drone1",  6'b000000, 1'b0, 1'b0, 1, 1'b1);
		addRow("beeOff",  6'b000000, 1'b1, 1'b1, 0, 1'b0);
		cycleLimit = rows.size() * 40 * SampleDiv * 2;

		repeat (8) @(posedge clock50Mhz);
		if (dacSyncN !== 1'b1 || dacSclk !== 1'b0 || dacDin !== 1'b0 || beeLed !== 1'b0) begin
			$display("ERR reset: sync sclk din led expected 1000 actual %b%b%b%b",
				dacSyncN, dacSclk, dacDin, beeLed);
			errCount++;
			failedRows++;
		end
		$display("reset     %s", (errCount == 0) ? "ok" : "FAIL");
		releaseReset();

		foreach (rows[r]) begin
			row       = rows[r];
			startErrs = errCount;
			hold      = 30 + ($urandom % 11); // 30 to 40 frames
			vals.delete();
			driveKeys(row.keyMask);
			if (row.beeToggle) pressBee();
			for (int i = 0; i < hold; i++) begin
				takeFrame(row.name, value, bee);
				if (i < SkipFrames) continue;
				vals.push_back(value);
				if (bee !== row.expBee) begin
					$display("ERR %s: beeLed expected %b actual %b", row.name, row.expBee, bee);
					errCount++;
				end
				if (row.silent && value != 16'h0000) begin
					$display("ERR %s: sample expected 0000 actual %h", row.name, value);
					errCount++;
				end
			end
			if (!row.silent) checkTone(row.name, vals, HalfPeriod[row.expKey]);
			if (errCount != startErrs) failedRows++;
			$display("%s  %s  %0d frames checked", row.name,
				(errCount == startErrs) ? "ok" : "FAIL", vals.size());
		end

		$display("Rows %0d, failed %0d, errors %0d", rows.size() + 1, failedRows, errCount);
		if (errCount == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
